// ==== logic/axi_wr_pkg.sv ====
package axi_wr_pkg;

  // Bus widths for a 32-bit data path
  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;
  typedef logic [3:0] id_t;
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;

  typedef enum logic [1:0] {
    FIXED = 2'd0,
    INCR  = 2'd1,
    WRAP  = 2'd2
  } burst_e;

  // Encoded so that a larger code is a worse response
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    EXOKAY = 2'd1,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } resp_e;

  // AXI write address request of 33 bits
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
  } aw_req_t;

  // One beat of a split burst in 21 bits
  typedef struct packed {
    id_t   id;
    addr_t addr;
    logic  last;
  } beat_t;

  // AXI write data beat of 37 bits
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_beat_t;

endpackage

// ==== logic/axi_burst_iter.sv ====
`timescale 1ns/1ns

module axi_burst_iter (
  input  logic                clk,
  input  logic                i_reset,

  input  logic                i_aw_valid,
  input  axi_wr_pkg::aw_req_t i_aw,
  output logic                o_aw_ready,

  output logic                o_beat_valid,
  output axi_wr_pkg::beat_t   o_beat,
  input  logic                i_beat_ready
);

  import axi_wr_pkg::*;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e state;

  // Registered copy of the request
  id_t    id_q;
  burst_e burst_q;
  addr_t  addr_q;
  addr_t  step_q;
  addr_t  wrap_mask_q;
  len_t   count_q;

  addr_t  addr_incr;
  addr_t  addr_next;
  logic   last_beat;

  assign o_aw_ready   = (state == IDLE);
  assign o_beat_valid = (state == RUN);

  assign last_beat = (count_q == '0);
  assign o_beat    = '{id: id_q, addr: addr_q, last: last_beat};

  assign addr_incr = addr_q + step_q;

  always_comb begin
    case (burst_q)
      FIXED: addr_next = addr_q;
      // Stay inside the aligned window of (len+1) beats
      WRAP: addr_next = (addr_q & ~wrap_mask_q) | (addr_incr & wrap_mask_q);
      default: addr_next = addr_incr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (i_aw_valid) begin
            state <= RUN;
          end
        end
        RUN: begin
          if (i_beat_ready && last_beat) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (o_aw_ready && i_aw_valid) begin
      id_q        <= i_aw.id;
      burst_q     <= i_aw.burst;
      addr_q      <= i_aw.addr;
      count_q     <= i_aw.len;
      step_q      <= addr_t'(1) << i_aw.size;
      // Window size in bytes minus one
      wrap_mask_q <= ((addr_t'(i_aw.len) + addr_t'(1)) << i_aw.size) - addr_t'(1);
    end else if (o_beat_valid && i_beat_ready) begin
      addr_q  <= addr_next;
      count_q <= count_q - 1'b1;
    end
  end

endmodule

// ==== logic/axi_beat_fifo.sv ====
`timescale 1ns/1ns

module axi_beat_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              i_reset,

  input  logic              i_push_valid,
  input  axi_wr_pkg::beat_t i_push,
  output logic              o_push_ready,

  output logic              o_pop_valid,
  output axi_wr_pkg::beat_t o_pop,
  input  logic              i_pop_ready
);

  import axi_wr_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  beat_t mem [FIFO_DEPTH];

  // Extra top bit tells full from empty
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

  assign o_push_ready = !full;
  assign o_pop_valid  = !empty;
  assign o_pop        = mem[rd_ptr[PTR_W-1:0]];

  assign push = i_push_valid && o_push_ready;
  assign pop  = o_pop_valid && i_pop_ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[PTR_W-1:0]] <= i_push;
    end
  end

endmodule

// ==== logic/axil_wr_issuer.sv ====
`timescale 1ns/1ns

module axil_wr_issuer (
  input  logic                clk,
  input  logic                i_reset,

  // Beat descriptors from the FIFO
  input  logic                i_beat_valid,
  input  axi_wr_pkg::beat_t   i_beat,
  output logic                o_beat_ready,

  // AXI W
  input  logic                i_w_valid,
  input  axi_wr_pkg::w_beat_t i_w,
  output logic                o_w_ready,

  // AXI B
  output logic                o_b_valid,
  output axi_wr_pkg::id_t     o_b_id,
  output axi_wr_pkg::resp_e   o_b_resp,
  input  logic                i_b_ready,

  // AXI-Lite write channels
  output logic                o_lite_aw_valid,
  output axi_wr_pkg::addr_t   o_lite_aw_addr,
  input  logic                i_lite_aw_ready,
  output logic                o_lite_w_valid,
  output axi_wr_pkg::data_t   o_lite_w_data,
  output axi_wr_pkg::strb_t   o_lite_w_strb,
  input  logic                i_lite_w_ready,
  input  logic                i_lite_b_valid,
  input  axi_wr_pkg::resp_e   i_lite_b_resp,
  output logic                o_lite_b_ready
);

  import axi_wr_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT_B,
    RESP
  } state_e;

  state_e state;

  beat_t  cur_beat;
  logic   aw_done;
  logic   w_done;
  resp_e  resp_acc;

  logic   aw_fire;
  logic   w_fire;
  logic   aw_done_next;
  logic   w_done_next;

  assign o_beat_ready = (state == IDLE);

  // AW and W of one beat go out together, each finishing on its own
  assign o_lite_aw_valid = (state == SEND) && !aw_done;
  assign o_lite_aw_addr  = cur_beat.addr;

  // W passes straight through while this beat still needs it
  assign o_lite_w_valid = (state == SEND) && !w_done && i_w_valid;
  assign o_w_ready      = (state == SEND) && !w_done && i_lite_w_ready;
  assign o_lite_w_data  = i_w.data;
  assign o_lite_w_strb  = i_w.strb;

  assign o_lite_b_ready = (state == WAIT_B);

  assign o_b_valid = (state == RESP);
  assign o_b_id    = cur_beat.id;
  assign o_b_resp  = resp_acc;

  assign aw_fire = o_lite_aw_valid && i_lite_aw_ready;
  assign w_fire  = o_lite_w_valid && i_lite_w_ready;

  assign aw_done_next = aw_done || aw_fire;
  assign w_done_next  = w_done || w_fire;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state    <= IDLE;
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
      resp_acc <= OKAY;
    end else begin
      case (state)
        IDLE: begin
          if (i_beat_valid) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= SEND;
          end
        end
        SEND: begin
          aw_done <= aw_done_next;
          w_done  <= w_done_next;
          if (aw_done_next && w_done_next) begin
            state <= WAIT_B;
          end
        end
        WAIT_B: begin
          if (i_lite_b_valid) begin
            // Keep the worst response of the burst
            if (i_lite_b_resp > resp_acc) begin
              resp_acc <= i_lite_b_resp;
            end
            state <= cur_beat.last ? RESP : IDLE;
          end
        end
        RESP: begin
          if (i_b_ready) begin
            // Next burst starts from OKAY
            resp_acc <= OKAY;
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Beat under service
  always_ff @(posedge clk) begin
    if (o_beat_ready && i_beat_valid) begin
      cur_beat <= i_beat;
    end
  end

endmodule

// ==== logic/axi_axil_adapter_wr.sv ====
`timescale 1ns/1ns

module axi_axil_adapter_wr #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                i_reset,

  // AXI subordinate side
  input  logic                i_aw_valid,
  input  axi_wr_pkg::aw_req_t i_aw,
  output logic                o_aw_ready,
  input  logic                i_w_valid,
  input  axi_wr_pkg::w_beat_t i_w,
  output logic                o_w_ready,
  output logic                o_b_valid,
  output axi_wr_pkg::id_t     o_b_id,
  output axi_wr_pkg::resp_e   o_b_resp,
  input  logic                i_b_ready,

  // AXI-Lite manager side
  output logic                o_lite_aw_valid,
  output axi_wr_pkg::addr_t   o_lite_aw_addr,
  input  logic                i_lite_aw_ready,
  output logic                o_lite_w_valid,
  output axi_wr_pkg::data_t   o_lite_w_data,
  output axi_wr_pkg::strb_t   o_lite_w_strb,
  input  logic                i_lite_w_ready,
  input  logic                i_lite_b_valid,
  input  axi_wr_pkg::resp_e   i_lite_b_resp,
  output logic                o_lite_b_ready
);

  import axi_wr_pkg::*;

  // Iterator to FIFO
  logic  push_valid;
  beat_t push_beat;
  logic  push_ready;

  // FIFO to issuer
  logic  pop_valid;
  beat_t pop_beat;
  logic  pop_ready;

  axi_burst_iter u_burst_iter (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_aw_valid   (i_aw_valid),
    .i_aw         (i_aw),
    .o_aw_ready   (o_aw_ready),
    .o_beat_valid (push_valid),
    .o_beat       (push_beat),
    .i_beat_ready (push_ready)
  );

  axi_beat_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_beat_fifo (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_push_valid (push_valid),
    .i_push       (push_beat),
    .o_push_ready (push_ready),
    .o_pop_valid  (pop_valid),
    .o_pop        (pop_beat),
    .i_pop_ready  (pop_ready)
  );

  axil_wr_issuer u_wr_issuer (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_beat_valid    (pop_valid),
    .i_beat          (pop_beat),
    .o_beat_ready    (pop_ready),
    .i_w_valid       (i_w_valid),
    .i_w             (i_w),
    .o_w_ready       (o_w_ready),
    .o_b_valid       (o_b_valid),
    .o_b_id          (o_b_id),
    .o_b_resp        (o_b_resp),
    .i_b_ready       (i_b_ready),
    .o_lite_aw_valid (o_lite_aw_valid),
    .o_lite_aw_addr  (o_lite_aw_addr),
    .i_lite_aw_ready (i_lite_aw_ready),
    .o_lite_w_valid  (o_lite_w_valid),
    .o_lite_w_data   (o_lite_w_data),
    .o_lite_w_strb   (o_lite_w_strb),
    .i_lite_w_ready  (i_lite_w_ready),
    .i_lite_b_valid  (i_lite_b_valid),
    .i_lite_b_resp   (i_lite_b_resp),
    .o_lite_b_ready  (o_lite_b_ready)
  );

endmodule

// ==== testbench/axi_axil_adapter_wr_props.sv ====
`timescale 1ns/1ns

module axi_axil_adapter_wr_props (
  input logic                clk,
  input logic                i_reset,
  input logic                o_lite_aw_valid,
  input axi_wr_pkg::addr_t   o_lite_aw_addr,
  input logic                i_lite_aw_ready,
  input logic                o_lite_w_valid,
  input axi_wr_pkg::data_t   o_lite_w_data,
  input axi_wr_pkg::strb_t   o_lite_w_strb,
  input logic                i_lite_w_ready,
  input logic                o_b_valid,
  input axi_wr_pkg::id_t     o_b_id,
  input axi_wr_pkg::resp_e   o_b_resp,
  input logic                i_b_ready
);

  // Each channel holds valid and payload until its handshake
  lite_aw_hold: assert property (@(posedge clk) disable iff (i_reset)
    o_lite_aw_valid && !i_lite_aw_ready |=> o_lite_aw_valid && $stable(o_lite_aw_addr))
    else $error("lite AW dropped or changed before handshake");

  lite_w_hold: assert property (@(posedge clk) disable iff (i_reset)
    o_lite_w_valid && !i_lite_w_ready |=>
      o_lite_w_valid && $stable(o_lite_w_data) && $stable(o_lite_w_strb))
    else $error("lite W dropped or changed before handshake");

  b_hold: assert property (@(posedge clk) disable iff (i_reset)
    o_b_valid && !i_b_ready |=> o_b_valid && $stable(o_b_id) && $stable(o_b_resp))
    else $error("B dropped or changed before handshake");

  b_quiet_in_reset: assert property (@(posedge clk) i_reset |=> !o_b_valid)
    else $error("B valid during reset");

endmodule

bind axi_axil_adapter_wr axi_axil_adapter_wr_props u_props (.*);

// ==== testbench/axi_axil_adapter_wr_tb.sv ====
`timescale 1ns/1ns

module axi_axil_adapter_wr_tb;

  import axi_wr_pkg::*;

  // Total beats of tests 1 to 6 (1 + 29 + 30 + 12 + 16 + 32)
  localparam int TOTAL_BEATS = 120;
  localparam int CYCLE_LIMIT = 40 * TOTAL_BEATS;

  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } wr_rec_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_rec_t;

  logic clk = 1'b0;
  logic i_reset;
  logic i_aw_valid, i_w_valid, i_b_ready;
  aw_req_t i_aw;
  w_beat_t i_w;
  logic i_lite_aw_ready, i_lite_w_ready, i_lite_b_valid;
  resp_e i_lite_b_resp;
  logic o_aw_ready, o_w_ready, o_b_valid, o_lite_aw_valid, o_lite_w_valid, o_lite_b_ready;
  id_t o_b_id;
  resp_e o_b_resp;
  addr_t o_lite_aw_addr;
  data_t o_lite_w_data;
  strb_t o_lite_w_strb;

  aw_req_t aw_q[$];
  w_beat_t w_q[$];
  wr_rec_t exp_wr_q[$], got_wr_q[$];
  b_rec_t  exp_b_q[$], got_b_q[$];

  int errors = 0;
  int failed_tests = 0;
  int cycles = 0;
  logic heavy_bp = 1'b0;

  // Subordinate model state
  logic aw_got, w_got, b_pending;
  addr_t lite_addr;
  data_t lite_data;
  strb_t lite_strb;
  int b_delay;

  axi_axil_adapter_wr #(.FIFO_DEPTH(4)) DUT (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the bridge stopped making progress after %0d cycles", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Expected address of beat i under the AXI burst rules
  function automatic addr_t beat_addr(aw_req_t r, int i);
    int bytes;
    int win;
    int base;
    bytes = 1 << r.size;
    win = (int'(r.len) + 1) * bytes;
    case (r.burst)
      FIXED: return r.addr;
      WRAP: begin
        base = (int'(r.addr) / win) * win;
        return addr_t'(base + ((int'(r.addr) - base + i * bytes) % win));
      end
      default: return addr_t'(int'(r.addr) + i * bytes);
    endcase
  endfunction

  function automatic resp_e addr_resp(addr_t a);
    return a[15] ? SLVERR : OKAY;
  endfunction

  task automatic add_burst(id_t id, addr_t addr, len_t len, size_t size, burst_e burst);
    aw_req_t r;
    data_t d;
    strb_t s;
    resp_e worst;
    addr_t a;
    r = '{id: id, addr: addr, len: len, size: size, burst: burst};
    worst = OKAY;
    for (int i = 0; i <= int'(len); i++) begin
      d = $urandom;
      s = strb_t'($urandom);
      a = beat_addr(r, i);
      w_q.push_back('{data: d, strb: s, last: (i == int'(len))});
      exp_wr_q.push_back('{addr: a, data: d, strb: s});
      if (addr_resp(a) > worst) worst = addr_resp(a);
    end
    exp_b_q.push_back('{id: id, resp: worst});
    aw_q.push_back(r);
  endtask

  task automatic finish_test(int num, string name, int err_start);
    while (exp_wr_q.size() != 0 || exp_b_q.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);
    if (errors != err_start) failed_tests++;
    $display("Test %0d %s: %0d errors", num, name, errors - err_start);
  endtask

  // AW manager
  always @(posedge clk) begin
    if (!i_reset && (!i_aw_valid || o_aw_ready)) begin
      if (aw_q.size() != 0) begin
        i_aw <= aw_q.pop_front();
        i_aw_valid <= 1'b1;
      end else begin
        i_aw_valid <= 1'b0;
      end
    end
  end

  // W stream with random gaps
  always @(posedge clk) begin
    if (!i_reset && (!i_w_valid || o_w_ready)) begin
      if (w_q.size() != 0 && $urandom % 3 != 0) begin
        i_w <= w_q.pop_front();
        i_w_valid <= 1'b1;
      end else begin
        i_w_valid <= 1'b0;
      end
    end
  end

  // AXI-Lite subordinate model
  always @(posedge clk) begin
    if (i_reset) begin
      aw_got = 1'b0;
      w_got = 1'b0;
      b_pending = 1'b0;
      i_lite_b_valid <= 1'b0;
    end else begin
      if (o_lite_aw_valid && i_lite_aw_ready) begin
        aw_got = 1'b1;
        lite_addr = o_lite_aw_addr;
      end
      if (o_lite_w_valid && i_lite_w_ready) begin
        w_got = 1'b1;
        lite_data = o_lite_w_data;
        lite_strb = o_lite_w_strb;
      end
      i_lite_aw_ready <= heavy_bp ? ($urandom % 3 == 0) : ($urandom % 4 != 0);
      i_lite_w_ready <= heavy_bp ? ($urandom % 3 == 0) : ($urandom % 4 != 0);
      if (aw_got && w_got && !b_pending) begin
        got_wr_q.push_back('{addr: lite_addr, data: lite_data, strb: lite_strb});
        b_pending = 1'b1;
        b_delay = int'($urandom % 4);
        aw_got = 1'b0;
        w_got = 1'b0;
      end
      if (i_lite_b_valid && o_lite_b_ready) begin
        i_lite_b_valid <= 1'b0;
        b_pending = 1'b0;
      end else if (b_pending && !i_lite_b_valid) begin
        if (b_delay == 0) begin
          i_lite_b_valid <= 1'b1;
          i_lite_b_resp <= addr_resp(lite_addr);
        end else begin
          b_delay--;
        end
      end
    end
  end

  // B ready and B monitor
  always @(posedge clk) begin
    if (!i_reset) begin
      if (o_b_valid && i_b_ready) got_b_q.push_back('{id: o_b_id, resp: o_b_resp});
      i_b_ready <= heavy_bp ? ($urandom % 4 == 0) : ($urandom % 4 != 0);
    end
  end

  // Comparator
  always @(posedge clk) begin
    wr_rec_t g;
    wr_rec_t e;
    b_rec_t gb;
    b_rec_t eb;
    if (got_wr_q.size() != 0) begin
      g = got_wr_q.pop_front();
      if (exp_wr_q.size() == 0) begin
        $display("An AXI-Lite write appeared that no burst asked for");
        errors++;
      end else begin
        e = exp_wr_q.pop_front();
        assert (g.addr == e.addr) else begin
          $display("[ERROR] o_lite_aw_addr got %h expected %h", g.addr, e.addr);
          errors++;
        end
        assert (g.data == e.data) else begin
          $display("[ERROR] o_lite_w_data got %h expected %h", g.data, e.data);
          errors++;
        end
        assert (g.strb == e.strb) else begin
          $display("[ERROR] o_lite_w_strb got %h expected %h", g.strb, e.strb);
          errors++;
        end
      end
    end
    if (got_b_q.size() != 0) begin
      gb = got_b_q.pop_front();
      if (exp_b_q.size() == 0) begin
        $display("A B response appeared with no burst outstanding");
        errors++;
      end else begin
        eb = exp_b_q.pop_front();
        assert (gb.id == eb.id) else begin
          $display("[ERROR] o_b_id got %h expected %h", gb.id, eb.id);
          errors++;
        end
        assert (gb.resp == eb.resp) else begin
          $display("[ERROR] o_b_resp got %h expected %h", gb.resp, eb.resp);
          errors++;
        end
      end
    end
  end

  initial begin
    int e0;
    void'($urandom(13891));
    i_reset = 1'b1;
    i_aw_valid = 1'b0;
    i_aw = '0;
    i_w_valid = 1'b0;
    i_w = '0;
    i_b_ready = 1'b0;
    i_lite_aw_ready = 1'b0;
    i_lite_w_ready = 1'b0;
    i_lite_b_valid = 1'b0;
    i_lite_b_resp = OKAY;
    repeat (8) @(posedge clk);
    i_reset <= 1'b0;

    e0 = errors;
    add_burst(4'h3, 16'h0040, 8'd0, 3'd2, INCR);
    finish_test(1, "single INCR", e0);

    e0 = errors;
    add_burst(4'h1, 16'h0100, 8'd0, 3'd2, INCR);
    add_burst(4'h2, 16'h0202, 8'd3, 3'd1, INCR);
    add_burst(4'h3, 16'h0301, 8'd7, 3'd0, INCR);
    add_burst(4'h4, 16'h0400, 8'd15, 3'd2, INCR);
    finish_test(2, "INCR lengths and sizes", e0);

    e0 = errors;
    add_burst(4'h5, 16'h0104, 8'd1, 3'd2, WRAP);
    add_burst(4'h6, 16'h0238, 8'd3, 3'd2, WRAP);
    add_burst(4'h7, 16'h0314, 8'd7, 3'd2, WRAP);
    add_burst(4'h8, 16'h0426, 8'd15, 3'd1, WRAP);
    finish_test(3, "WRAP bursts", e0);

    e0 = errors;
    add_burst(4'h9, 16'h0500, 8'd3, 3'd2, FIXED);
    add_burst(4'hA, 16'h8504, 8'd3, 3'd2, FIXED);
    add_burst(4'hB, 16'h0602, 8'd3, 3'd1, FIXED);
    finish_test(4, "FIXED bursts", e0);

    e0 = errors;
    add_burst(4'hC, 16'h7FF0, 8'd7, 3'd2, INCR);
    add_burst(4'hD, 16'h1000, 8'd7, 3'd2, INCR);
    finish_test(5, "response merging", e0);

    e0 = errors;
    heavy_bp = 1'b1;
    for (int i = 0; i < 8; i++) begin
      add_burst(id_t'(i), addr_t'($urandom) & 16'hFFC0, 8'd3, 3'd2, INCR);
    end
    finish_test(6, "back-pressure", e0);
    heavy_bp = 1'b0;

    $display("Tests: 6 run, %0d failed, %0d errors", failed_tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== axi_axil_adapter_wr.f ====
logic/axi_wr_pkg.sv
logic/axi_burst_iter.sv
logic/axi_beat_fifo.sv
logic/axil_wr_issuer.sv
logic/axi_axil_adapter_wr.sv
testbench/axi_axil_adapter_wr_props.sv
testbench/axi_axil_adapter_wr_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module axi_axil_adapter_wr_tb \
  -f axi_axil_adapter_wr.f \
  -o sim

out="$(./obj_dir/sim)"
echo "$out"

if echo "$out" | grep -q "=== PASS ==="; then
  exit 0
else
  exit 1
fi
